// ==== fpuCmpPkg.sv ====
// shared definitions for the single-precision compare unit.
// formats, class indices, operation codes and the float word view.
package fpuCmpPkg;

        // binary32 format widths.
        localparam int FLEN = 32;
        localparam int NEXP = 8;
        localparam int NSIG = 23;

        localparam int EXP_BIAS = 127;

        // width of the one-hot class vector and of the FCLASS result mask.
        localparam int NCLASS = 6;
        localparam int NMASK  = 10;

        // bit positions inside the one-hot class vector.
        localparam int CLASS_BIT_ZERO = 0;
        localparam int CLASS_BIT_SUB  = 1;
        localparam int CLASS_BIT_NORM = 2;
        localparam int CLASS_BIT_INF  = 3;
        localparam int CLASS_BIT_QNAN = 4;
        localparam int CLASS_BIT_SNAN = 5;

        // the RISC-V canonical quiet NaN that min/max returns for two NaNs.
        localparam logic [FLEN-1:0] CANON_NAN = 32'h7fc00000;

        // operation select. codes 6 and 7 are not used.
        typedef enum logic [2:0] {
                OP_FEQ    = 3'd0,
                OP_FLT    = 3'd1,
                OP_FLE    = 3'd2,
                OP_FMIN   = 3'd3,
                OP_FMAX   = 3'd4,
                OP_FCLASS = 3'd5
        } fpuOp_e;

        // field layout of a binary32 word, most significant field first.
        typedef struct packed {
                logic            sign;
                logic [NEXP-1:0] exp;  // biased exponent.
                logic [NSIG-1:0] frac; // stored fraction without the hidden bit.
        } floatFields_t;

        // the same 32 bits read either as a plain word or as its fields.
        typedef union packed {
                logic [FLEN-1:0] raw;
                floatFields_t    f;
        } floatWord_u;

endpackage

// ==== fpOperandIf.sv ====
// one unpacked binary32 operand, passed from an unpacker to the compare units.
interface fpOperandIf import fpuCmpPkg::*; ();

        logic [FLEN-1:0]          raw;  // the original word that min/max may return.
        logic                     sign;
        logic signed [NEXP+1:0]   exp;  // unbiased with two guard bits so differences never wrap.
        logic [NSIG:0]            sig;  // significand including the hidden bit.
        logic [NCLASS-1:0]        cls;  // one-hot class indexed by CLASS_BIT_*.

        // the unpacker drives every field.
        modport prod (
                output raw,
                output sign,
                output exp,
                output sig,
                output cls
        );

        // compare, min/max and classify only read them.
        modport cons (
                input raw,
                input sign,
                input exp,
                input sig,
                input cls
        );

endinterface

// ==== fpUnpack.sv ====
// binary32 unpacker.
// splits a raw word into sign, unbiased exponent, significand and a one-hot class.
module fpUnpack import fpuCmpPkg::*; (
        input  logic [31:0]     raw_i,
        fpOperandIf.prod        opOut
);

        floatWord_u             word;
        logic                   expOnes;
        logic                   expZero;
        logic                   fracZero;
        logic [NEXP-1:0]        expEff;

        assign word = floatWord_u'(raw_i);

        assign expOnes  = &word.f.exp;
        assign expZero  = ~|word.f.exp;
        assign fracZero = ~|word.f.frac;

        // subnormals and zero share the exponent of the smallest normal.
        // with the hidden bit cleared they then line up with normals,
        // so magnitudes compare correctly without shifting the fraction.
        assign expEff = expZero ? NEXP'(1) : word.f.exp;

        assign opOut.raw  = raw_i;
        assign opOut.sign = word.f.sign;
        assign opOut.exp  = {2'b00, expEff} - EXP_BIAS[NEXP+1:0]; // -126 up to +128.
        assign opOut.sig  = {~expZero, word.f.frac};

        always_comb begin
                opOut.cls = '0;
                if (expOnes) begin
                        if (fracZero) begin
                                opOut.cls[CLASS_BIT_INF] = 1'b1;
                        end else if (word.f.frac[NSIG-1]) begin
                                opOut.cls[CLASS_BIT_QNAN] = 1'b1; // quiet bit set.
                        end else begin
                                opOut.cls[CLASS_BIT_SNAN] = 1'b1;
                        end
                end else if (expZero) begin
                        if (fracZero) begin
                                opOut.cls[CLASS_BIT_ZERO] = 1'b1;
                        end else begin
                                opOut.cls[CLASS_BIT_SUB] = 1'b1;
                        end
                end else begin
                        opOut.cls[CLASS_BIT_NORM] = 1'b1;
                end

                // every encoding belongs to exactly one class.
                assert final ($onehot(opOut.cls))
                else $error("fpUnpack: class vector %b is not one-hot", opOut.cls);
        end

endmodule

// ==== fpCompare.sv ====
// FEQ/FLT/FLE comparator for two unpacked binary32 operands.
// drives {lt, le, eq} of a against b, all zero when either operand is a NaN.
module fpCompare import fpuCmpPkg::*; (
        fpOperandIf.cons        a,
        fpOperandIf.cons        b,
        output logic [2:0]      cmp_o // {lt, le, eq}.
);

        logic                   aNan;
        logic                   bNan;
        logic signed [NSIG+1:0] sigDiff;
        logic signed [NEXP+2:0] expDiff;
        logic                   expEq;
        logic                   sigEq;
        logic                   absEq;
        logic                   absALtB;
        logic                   absALeB;
        logic                   absBLtA;
        logic                   absBLeA;
        logic                   aLtB;
        logic                   aLeB;
        logic                   aEqB;

        assign aNan = a.cls[CLASS_BIT_QNAN] | a.cls[CLASS_BIT_SNAN];
        assign bNan = b.cls[CLASS_BIT_QNAN] | b.cls[CLASS_BIT_SNAN];

        // differences are taken as b minus a, so a set top bit means a is larger.
        assign sigDiff = {1'b0, b.sig} - {1'b0, a.sig};
        assign expDiff = {b.exp[NEXP+1], b.exp} - {a.exp[NEXP+1], a.exp};

        assign expEq = (expDiff == '0);
        assign sigEq = (sigDiff == '0);
        assign absEq = expEq & sigEq;

        // magnitude ordering from the exponent first, then the significand.
        assign absALtB = (!expDiff[NEXP+2] && !expEq) ||
                         (expEq && !sigEq && !sigDiff[NSIG+1]);
        assign absALeB = (!expDiff[NEXP+2] && !expEq) ||
                         (expEq && !sigDiff[NSIG+1]);
        assign absBLtA = expDiff[NEXP+2] || (expEq && sigDiff[NSIG+1]);
        assign absBLeA = expDiff[NEXP+2] || (expEq && (sigDiff[NSIG+1] || sigEq));

        // for two negatives the magnitude order flips.
        assign aLtB = (a.sign && !b.sign) ||
                      (a.sign && b.sign && absBLtA) ||
                      (!a.sign && !b.sign && absALtB);
        assign aLeB = (a.sign && !b.sign) ||
                      (a.sign && b.sign && absBLeA) ||
                      (!a.sign && !b.sign && absALeB);
        assign aEqB = absEq && (a.sign == b.sign);

        always_comb begin
                if (aNan || bNan) begin
                        cmp_o = 3'b000; // unordered.
                end else if (a.cls[CLASS_BIT_INF]) begin
                        if (!a.sign) begin
                                // +inf only equals +inf and is never less.
                                if (b.cls[CLASS_BIT_INF] && !b.sign) begin
                                        cmp_o = 3'b011;
                                end else begin
                                        cmp_o = 3'b000;
                                end
                        end else begin
                                if (b.cls[CLASS_BIT_INF] && b.sign) begin
                                        cmp_o = 3'b011;
                                end else begin
                                        cmp_o = 3'b110;
                                end
                        end
                end else if (b.cls[CLASS_BIT_INF]) begin
                        cmp_o = b.sign ? 3'b000 : 3'b110; // a is finite here.
                end else if (a.cls[CLASS_BIT_ZERO] && b.cls[CLASS_BIT_ZERO]) begin
                        cmp_o = 3'b011; // +0 and -0 compare equal.
                end else begin
                        cmp_o = {aLtB, aLeB, aEqB};
                end

                // lt and eq are both refinements of le.
                assert final ((!cmp_o[2] || cmp_o[1]) && (!cmp_o[0] || cmp_o[1]))
                else $error("fpCompare: inconsistent result %b", cmp_o);
        end

endmodule

// ==== fpMinMax.sv ====
// RISC-V FMIN/FMAX selection for two unpacked binary32 operands.
// reuses the comparator's lt/eq outputs and applies the NaN and signed-zero rules.
module fpMinMax import fpuCmpPkg::*; (
        fpOperandIf.cons        a,
        fpOperandIf.cons        b,
        input  logic            isMax_i,
        input  logic            lt_i,
        input  logic            eq_i,
        output logic [31:0]     result_o
);

        logic           aNan;
        logic           bNan;
        logic           bothZero;
        logic           pickA;
        floatWord_u     zeroRes;

        assign aNan = a.cls[CLASS_BIT_QNAN] | a.cls[CLASS_BIT_SNAN];
        assign bNan = b.cls[CLASS_BIT_QNAN] | b.cls[CLASS_BIT_SNAN];

        assign bothZero = eq_i & a.cls[CLASS_BIT_ZERO] & b.cls[CLASS_BIT_ZERO];

        // among two zeros the minimum is negative if either one is,
        // the maximum only if both are.
        always_comb begin
                zeroRes.f.sign = isMax_i ? (a.sign & b.sign) : (a.sign | b.sign);
                zeroRes.f.exp  = '0;
                zeroRes.f.frac = '0;
        end

        // ordered operands. equal non-zero values are the same word, so either will do.
        assign pickA = isMax_i ? ~lt_i : lt_i;

        always_comb begin
                if (aNan && bNan) begin
                        result_o = CANON_NAN;
                end else if (aNan) begin
                        result_o = b.raw; // a NaN loses to any number.
                end else if (bNan) begin
                        result_o = a.raw;
                end else if (bothZero) begin
                        result_o = zeroRes.raw;
                end else begin
                        result_o = pickA ? a.raw : b.raw;
                end
        end

endmodule

// ==== fpClassify.sv ====
// FCLASS for binary32. builds the ten-bit RISC-V class mask of one operand.
module fpClassify import fpuCmpPkg::*; (
        fpOperandIf.cons        a,
        output logic [9:0]      mask_o
);

        logic   neg;
        logic   pos;

        assign neg = a.sign;
        assign pos = ~a.sign;

        always_comb begin
                mask_o[0] = neg & a.cls[CLASS_BIT_INF];
                mask_o[1] = neg & a.cls[CLASS_BIT_NORM];
                mask_o[2] = neg & a.cls[CLASS_BIT_SUB];
                mask_o[3] = neg & a.cls[CLASS_BIT_ZERO];
                mask_o[4] = pos & a.cls[CLASS_BIT_ZERO];
                mask_o[5] = pos & a.cls[CLASS_BIT_SUB];
                mask_o[6] = pos & a.cls[CLASS_BIT_NORM];
                mask_o[7] = pos & a.cls[CLASS_BIT_INF];
                mask_o[8] = a.cls[CLASS_BIT_SNAN]; // NaN classes ignore the sign.
                mask_o[9] = a.cls[CLASS_BIT_QNAN];

                // relies on the unpacker's class vector staying one-hot.
                assert final ($onehot(mask_o))
                else $error("fpClassify: mask %b is not one-hot", mask_o);
        end

endmodule

// ==== fpuCmpTop.sv ====
// single-precision compare unit: FEQ, FLT, FLE, FMIN, FMAX and FCLASS.
// one request per valid cycle, result and NV flag registered one cycle later.
module fpuCmpTop import fpuCmpPkg::*; (
        input  logic            clk_i,
        input  logic            rstN_i,
        input  logic            valid_i,
        input  fpuOp_e          op_i,
        input  logic [31:0]     rs1_i,
        input  logic [31:0]     rs2_i,
        output logic            resultValid_o,
        output logic [31:0]     result_o,
        output logic            nv_o
);

        fpOperandIf             opA ();
        fpOperandIf             opB ();

        logic [2:0]             cmp;
        logic [FLEN-1:0]        minMaxRes;
        logic [NMASK-1:0]       classMask;
        logic                   anyNan;
        logic                   anySnan;
        logic [FLEN-1:0]        resultNext;
        logic                   nvNext;

        fpUnpack u_unpackA (
                .raw_i (rs1_i),
                .opOut (opA.prod)
        );

        fpUnpack u_unpackB (
                .raw_i (rs2_i),
                .opOut (opB.prod)
        );

        fpCompare u_compare (
                .a     (opA.cons),
                .b     (opB.cons),
                .cmp_o (cmp)
        );

        fpMinMax u_minMax (
                .a        (opA.cons),
                .b        (opB.cons),
                .isMax_i  (op_i == OP_FMAX),
                .lt_i     (cmp[2]),
                .eq_i     (cmp[0]),
                .result_o (minMaxRes)
        );

        fpClassify u_classify (
                .a      (opA.cons),
                .mask_o (classMask)
        );

        assign anySnan = opA.cls[CLASS_BIT_SNAN] | opB.cls[CLASS_BIT_SNAN];
        assign anyNan  = anySnan | opA.cls[CLASS_BIT_QNAN] | opB.cls[CLASS_BIT_QNAN];

        always_comb begin
                resultNext = '0;
                nvNext     = 1'b0;
                case (op_i)
                        OP_FEQ: begin
                                resultNext = {{(FLEN-1){1'b0}}, cmp[0]};
                                nvNext     = anySnan; // quiet compare.
                        end
                        OP_FLT: begin
                                resultNext = {{(FLEN-1){1'b0}}, cmp[2]};
                                nvNext     = anyNan; // signalling compare.
                        end
                        OP_FLE: begin
                                resultNext = {{(FLEN-1){1'b0}}, cmp[1]};
                                nvNext     = anyNan;
                        end
                        OP_FMIN, OP_FMAX: begin
                                resultNext = minMaxRes;
                                nvNext     = anySnan;
                        end
                        OP_FCLASS: begin
                                resultNext = {{(FLEN-NMASK){1'b0}}, classMask};
                        end
                        default: begin
                                resultNext = '0;
                        end
                endcase
        end

        // result and flag only load on a request, so they hold between pulses.
        always_ff @(posedge clk_i or negedge rstN_i) begin
                if (!rstN_i) begin
                        resultValid_o <= 1'b0;
                        result_o      <= '0;
                        nv_o          <= 1'b0;
                end else begin
                        resultValid_o <= valid_i;
                        if (valid_i) begin
                                result_o <= resultNext;
                                nv_o     <= nvNext;
                        end
                end
        end

        // the unused codes 6 and 7 must never be issued.
        assert property (@(posedge clk_i) disable iff (!rstN_i)
                valid_i |-> (op_i inside {OP_FEQ, OP_FLT, OP_FLE, OP_FMIN, OP_FMAX, OP_FCLASS}))
        else $error("fpuCmpTop: request with unused operation code %0d", op_i);

endmodule

// ==== fpuCmpTbModel.svh ====
// reference model of the compare unit and the random source for its testbench.
// included inside the testbench module, so it sees the package imports there.
`ifndef FPU_CMP_TB_MODEL_SVH
`define FPU_CMP_TB_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'h16a13da3;
localparam logic [31:0] LFSR_TAPS = 32'h80200003; // x^32 + x^22 + x^2 + x + 1.

logic [31:0] lfsrState = LFSR_SEED;

// one Galois step that returns the bit shifted out.
function automatic logic nextBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) lfsrState = lfsrState ^ LFSR_TAPS;
        return outBit;
endfunction

function automatic logic [31:0] randBits(int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) value = {value[30:0], nextBit()};
        return value;
endfunction

function automatic logic isNan(logic [31:0] x);
        return (x[30:23] == 8'hff) && (x[22:0] != 23'h0);
endfunction

function automatic logic isSnan(logic [31:0] x);
        return isNan(x) && !x[22]; // quiet bit clear.
endfunction

// maps a non-NaN float onto a signed integer with the same ordering.
// both zeros land on 0, which makes them equal.
function automatic logic signed [32:0] orderKey(logic [31:0] x);
        logic signed [32:0] mag;
        mag = $signed({2'b00, x[30:0]});
        return x[31] ? -mag : mag;
endfunction

function automatic logic [9:0] classMask(logic [31:0] x);
        logic [9:0] m;
        m = '0;
        if (isNan(x)) m[x[22] ? 9 : 8] = 1'b1;
        else if (x[30:23] == 8'hff) m[x[31] ? 0 : 7] = 1'b1;
        else if (x[30:0] == 31'h0) m[x[31] ? 3 : 4] = 1'b1;
        else if (x[30:23] == 8'h00) m[x[31] ? 2 : 5] = 1'b1;
        else m[x[31] ? 1 : 6] = 1'b1;
        return m;
endfunction

function automatic logic [31:0] minMax(logic isMax, logic [31:0] a, logic [31:0] b);
        if (isNan(a) && isNan(b)) return CANON_NAN;
        if (isNan(a)) return b;
        if (isNan(b)) return a;
        if (a[30:0] == 31'h0 && b[30:0] == 31'h0) begin
                if (isMax) return a[31] ? b : a; // the positive zero wins.
                return a[31] ? a : b;
        end
        if (isMax) return (orderKey(a) >= orderKey(b)) ? a : b;
        return (orderKey(a) <= orderKey(b)) ? a : b;
endfunction

function automatic logic [31:0] modelResult(fpuOp_e op, logic [31:0] a, logic [31:0] b);
        logic unordered;
        unordered = isNan(a) || isNan(b);
        case (op)
                OP_FEQ:  return {31'h0, !unordered && (orderKey(a) == orderKey(b))};
                OP_FLT:  return {31'h0, !unordered && (orderKey(a) < orderKey(b))};
                OP_FLE:  return {31'h0, !unordered && (orderKey(a) <= orderKey(b))};
                OP_FMIN: return minMax(1'b0, a, b);
                OP_FMAX: return minMax(1'b1, a, b);
                default: return {22'h0, classMask(a)};
        endcase
endfunction

function automatic logic modelNv(fpuOp_e op, logic [31:0] a, logic [31:0] b);
        case (op)
                OP_FLT, OP_FLE: return isNan(a) || isNan(b);
                OP_FCLASS:      return 1'b0;
                default:        return isSnan(a) || isSnan(b);
        endcase
endfunction

`endif

// ==== fpuCmpTb.sv ====
// testbench for the compare unit.
// directed corner cases and random requests, checked by assertions against the model.
module fpuCmpTb import fpuCmpPkg::*; ();

        localparam int CLK_PERIOD   = 100;
        localparam int NUM_DIRECTED = 38;
        localparam int NUM_RANDOM   = 2000;
        localparam int TIMEOUT      = (NUM_DIRECTED + NUM_RANDOM + 20) * CLK_PERIOD;

        // operand encodings used by the directed tests.
        localparam logic [31:0] P_ZERO   = 32'h00000000;
        localparam logic [31:0] N_ZERO   = 32'h80000000;
        localparam logic [31:0] P_INF    = 32'h7f800000;
        localparam logic [31:0] N_INF    = 32'hff800000;
        localparam logic [31:0] QNAN     = 32'h7fc00000;
        localparam logic [31:0] N_QNAN   = 32'hffc00001;
        localparam logic [31:0] SNAN     = 32'h7f800001;
        localparam logic [31:0] MIN_NORM = 32'h00800000;
        localparam logic [31:0] MAX_SUB  = 32'h007fffff;
        localparam logic [31:0] N_SUB    = 32'h807fffff;
        localparam logic [31:0] ONE      = 32'h3f800000;
        localparam logic [31:0] N_ONE    = 32'hbf800000;
        localparam logic [31:0] TWO      = 32'h40000000;

        logic           clk = 1'b0;
        logic           rstN;
        logic           valid;
        fpuOp_e         op;
        logic [31:0]    rs1;
        logic [31:0]    rs2;
        logic           resultValid;
        logic [31:0]    result;
        logic           nv;

        logic [31:0]    reqResult;  // expectation of the request being driven.
        logic           reqNv;
        logic [31:0]    expResult = '0;  // expectation of the request now in flight.
        logic           expNv = 1'b0;
        int             reqCount = 0;
        int             errorCount = 0;

`include "fpuCmpTbModel.svh"

        fpuCmpTop u_fpuCmpTop (
                .clk_i         (clk),
                .rstN_i        (rstN),
                .valid_i       (valid),
                .op_i          (op),
                .rs1_i         (rs1),
                .rs2_i         (rs2),
                .resultValid_o (resultValid),
                .result_o      (result),
                .nv_o          (nv)
        );

        always #(CLK_PERIOD / 2) clk = ~clk;

        // one-deep expectation register that loads when the DUT takes a request.
        always @(posedge clk) begin
                if (valid) begin
                        expResult <= reqResult;
                        expNv     <= reqNv;
                end
        end

        task automatic reportMismatch(string name, logic [31:0] expected, logic [31:0] actual);
                errorCount++;
                $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
        endtask

        assert property (@(posedge clk) disable iff (!rstN) valid |=> resultValid)
        else reportMismatch("resultValid_o", 32'd1, $sampled(resultValid));

        // no pulse without a request.
        assert property (@(posedge clk) disable iff (!rstN) !valid |=> !resultValid)
        else reportMismatch("resultValid_o", 32'd0, $sampled(resultValid));

        assert property (@(posedge clk) disable iff (!rstN) valid |=> (result == expResult))
        else reportMismatch("result_o", $sampled(expResult), $sampled(result));

        assert property (@(posedge clk) disable iff (!rstN) valid |=> (nv == expNv))
        else reportMismatch("nv_o", $sampled(expNv), $sampled(nv));

        // between pulses the result and the flag keep the last request's values.
        assert property (@(posedge clk) disable iff (!rstN) !valid |=> (result == expResult))
        else reportMismatch("result_o", $sampled(expResult), $sampled(result));

        assert property (@(posedge clk) disable iff (!rstN) !valid |=> (nv == expNv))
        else reportMismatch("nv_o", $sampled(expNv), $sampled(nv));

        task automatic request(fpuOp_e reqOp, logic [31:0] a, logic [31:0] b);
                @(negedge clk);
                valid     = 1'b1;
                op        = reqOp;
                rs1       = a;
                rs2       = b;
                reqResult = modelResult(reqOp, a, b);
                reqNv     = modelNv(reqOp, a, b);
                reqCount++;
        endtask

        task automatic idleCycle();
                @(negedge clk);
                valid = 1'b0;
        endtask

        // picks a class first so that special encodings show up often.
        function automatic logic [31:0] randOperand();
                logic [31:0] kind;
                logic [31:0] sgn;
                logic [31:0] frac;
                kind = randBits(3);
                sgn  = randBits(1);
                frac = '0;
                if (kind[2:0] == 3'd1) begin
                        frac = randBits(23);
                end else if (kind[2:0] == 3'd3 || kind[2:0] == 3'd4) begin
                        frac = randBits(22);
                end else if (kind[2:0] > 3'd4) begin
                        frac = randBits(31);
                end
                case (kind[2:0])
                        3'd0:    return {sgn[0], 31'h0};
                        3'd1:    return {sgn[0], 8'h00, frac[22:0] | 23'h1};
                        3'd2:    return {sgn[0], 8'hff, 23'h0};
                        3'd3:    return {sgn[0], 8'hff, 1'b1, frac[21:0]};
                        3'd4:    return {sgn[0], 8'hff, 1'b0, frac[21:0] | 22'h1};
                        default: return {sgn[0], frac[30:0]};
                endcase
        endfunction

        function automatic fpuOp_e randOp();
                logic [31:0] code;
                code = randBits(3);
                while (code > 5) code = randBits(3); // codes 6 and 7 are unused.
                return fpuOp_e'(code[2:0]);
        endfunction

        initial begin
                #(TIMEOUT);
                $display("timeout: the DUT stopped answering, requests: %0d, errors: %0d",
                         reqCount, errorCount);
                $display("Test failures found");
                $finish;
        end

        initial begin
                rstN  = 1'b0;
                valid = 1'b0;
                op    = OP_FEQ;
                rs1   = '0;
                rs2   = '0;
                repeat (2) @(negedge clk);
                assert (resultValid === 1'b0) else reportMismatch("resultValid_o", 0, resultValid);
                assert (nv === 1'b0) else reportMismatch("nv_o", 0, nv);
                assert (result === 32'h0) else reportMismatch("result_o", 0, result);
                rstN = 1'b1;
                idleCycle();

                // ordered comparisons.
                request(OP_FEQ, P_ZERO, N_ZERO);
                request(OP_FLT, P_ZERO, N_ZERO);
                request(OP_FLE, N_ZERO, P_ZERO);
                request(OP_FLT, N_INF, P_INF);
                request(OP_FLE, P_INF, P_INF);
                request(OP_FEQ, N_INF, N_INF);
                request(OP_FLT, MAX_SUB, MIN_NORM);
                request(OP_FLT, MIN_NORM, MAX_SUB);
                request(OP_FLE, N_ONE, TWO);
                request(OP_FLT, TWO, ONE);
                request(OP_FEQ, ONE, ONE);
                request(OP_FLE, P_INF, ONE);
                idleCycle();

                // unordered comparisons.
                request(OP_FEQ, QNAN, ONE);
                request(OP_FEQ, SNAN, ONE);
                request(OP_FLT, QNAN, ONE);
                request(OP_FLE, ONE, SNAN);
                request(OP_FLT, QNAN, QNAN);
                request(OP_FEQ, QNAN, QNAN);

                request(OP_FMIN, N_ZERO, P_ZERO);
                request(OP_FMIN, P_ZERO, N_ZERO);
                request(OP_FMAX, N_ZERO, P_ZERO);
                request(OP_FMIN, QNAN, ONE);
                request(OP_FMAX, TWO, SNAN);
                request(OP_FMIN, QNAN, SNAN);
                request(OP_FMAX, N_QNAN, QNAN);
                request(OP_FMIN, N_ONE, TWO);
                request(OP_FMAX, N_ONE, TWO);
                request(OP_FMAX, N_INF, MAX_SUB);

                // every class once with a signalling NaN in rs2 that must not raise NV.
                request(OP_FCLASS, N_INF, SNAN);
                request(OP_FCLASS, N_ONE, SNAN);
                request(OP_FCLASS, N_SUB, SNAN);
                request(OP_FCLASS, N_ZERO, SNAN);
                request(OP_FCLASS, P_ZERO, SNAN);
                request(OP_FCLASS, MAX_SUB, SNAN);
                request(OP_FCLASS, ONE, SNAN);
                request(OP_FCLASS, P_INF, SNAN);
                request(OP_FCLASS, SNAN, SNAN);
                request(OP_FCLASS, QNAN, SNAN);

                for (int i = 0; i < NUM_RANDOM; i++) begin
                        fpuOp_e rndOp;
                        logic [31:0] a;
                        logic [31:0] b;
                        rndOp = randOp();
                        a = randOperand();
                        b = randOperand();
                        request(rndOp, a, b);
                end
                idleCycle();
                idleCycle();

                $display("requests: %0d, errors: %0d", reqCount, errorCount);
                if (errorCount == 0) begin
                        $display("All tests passed!");
                end else begin
                        $display("Test failures found");
                end
                $finish;
        end

endmodule

// ==== files.f ====
+incdir+.
fpuCmpPkg.sv
fpOperandIf.sv
fpUnpack.sv
fpCompare.sv
fpMinMax.sv
fpClassify.sv
fpuCmpTop.sv
fpuCmpTb.sv
